//--- src.f
verilog/lanzonesPkg.sv
verilog/regFile.sv
verilog/instDecoder.sv
verilog/aluUnit.sv
verilog/busSequencer.sv
verilog/lanzonesCore.sv
verif/tbClock.sv
verif/lanzonesAsserts.sv
verif/lanzonesTb.sv

//--- verif/lanzonesAsserts.sv
`timescale 1ns/1ps

module lanzonesAsserts (
   input logic        clk,
   input logic        rstn,
   input logic        halt,
   input logic        busRdy,
   input logic        busWEn,
   input logic        busVld,
   input logic [31:0] busAddr,
   input logic [31:0] busWData
);

   // No request while stopped
   haltIdle: assert property (@(posedge clk) disable iff (!rstn) halt |-> !busRdy)
      else $error("Bus request raised while the core is halted");

   wenWithRdy: assert property (@(posedge clk) disable iff (!rstn) busWEn |-> busRdy)
      else $error("Write enable high without a bus request");

   // Request held until memory answers
   reqStable: assert property (@(posedge clk) disable iff (!rstn)
      (busRdy && !busVld) |=> ($stable(busAddr) && $stable(busWEn)))
      else $error("Bus address or write enable changed during a pending request");

   wdataStable: assert property (@(posedge clk) disable iff (!rstn)
      (busRdy && busWEn && !busVld) |=> $stable(busWData))
      else $error("Bus write data changed during a pending write");

endmodule

bind lanzonesCore lanzonesAsserts i_asserts (.*);

//--- verif/lanzonesTb.sv
`timescale 1ns/1ps

module lanzonesTb import lanzonesPkg::*; ();

   localparam int    periodNs     = 100;
   localparam int    resetCycles  = 10;
   localparam int    memWords     = 2048;
   localparam int    maxCycles    = 20000;
   localparam word_t resBase      = 32'h1000;
   localparam word_t dataAddr     = 32'h0800;
   localparam word_t guardAddr    = 32'h17f0;
   localparam word_t invGuardAddr = 32'h17f4;
   localparam int    clsR = 0, clsI = 1, clsLui = 2, clsLw = 3, clsX0 = 4;

   logic   clk, rstn, loadEn, halt, busRdy, busWEn, busVld;
   word_t  busAddr, busWData, busRData;
   word_t  mem [memWords];
   integer seed = 32'h8bce_3fb2;
   int     errCnt = 0;
   int     delay = 0;
   logic   armed = 1'b0;
   int     pcIdx;
   int     haltIdx;

   string      rowName[$];
   int         rowCls[$];
   logic [2:0] rowF3[$];
   logic [6:0] rowF7[$];
   word_t      rowA[$], rowB[$], rowExp[$];

   tbClock #(.periodNs(periodNs), .resetCycles(resetCycles)) i_clock (.clk(clk), .rstn(rstn));

   lanzonesCore i_dut (.*);

   // Memory answers each request after 0 to 3 cycles
   always @(negedge clk) begin
      if (!rstn) begin
         busVld = 1'b0;
         armed  = 1'b0;
      end
      else if (busVld) begin
         busVld = 1'b0;
      end
      else if (busRdy) begin
         if (!armed) begin
            delay = $random(seed) & 3;
            armed = 1'b1;
         end
         if (delay == 0) begin
            armed  = 1'b0;
            busVld = 1'b1;
            if (busWEn) mem[busAddr[12:2]] = busWData;
            else busRData = mem[busAddr[12:2]];
         end
         else begin
            delay--;
         end
      end
   end

   function automatic word_t encR(logic [6:0] f7, regIdx_t s2, regIdx_t s1, logic [2:0] f3,
                                  regIdx_t d);
      return {f7, s2, s1, f3, d, opOp};
   endfunction

   function automatic word_t encI(logic [11:0] i, regIdx_t s1, logic [2:0] f3, regIdx_t d,
                                  logic [6:0] op);
      return {i, s1, f3, d, op};
   endfunction

   function automatic word_t encS(logic [11:0] i, regIdx_t s2, regIdx_t s1);
      return {i[11:5], s2, s1, f3Word, i[4:0], opStore};
   endfunction

   function automatic word_t encU(logic [19:0] u, regIdx_t d);
      return {u, d, opLui};
   endfunction

   task automatic addRow(string n, int c, logic [2:0] f3, logic [6:0] f7, word_t a, word_t b,
                         word_t e);
      rowName.push_back(n);
      rowCls.push_back(c);
      rowF3.push_back(f3);
      rowF7.push_back(f7);
      rowA.push_back(a);
      rowB.push_back(b);
      rowExp.push_back(e);
   endtask

   task automatic emit(word_t w);
      mem[pcIdx] = w;
      pcIdx++;
   endtask

   // LUI plus ADDI, upper part rounded for the signed low half
   task automatic emitConst(regIdx_t d, word_t v);
      word_t upper;
      upper = (v + 32'h800) >> 12;
      emit(encU(upper[19:0], d));
      emit(encI(v[11:0], d, 3'b000, d, opOpImm));
   endtask

   task automatic buildProgram();
      logic [11:0] immOp;
      pcIdx = 0;
      emit(encU(20'h1, 5));
      for (int k = 0; k < rowName.size(); k++) begin
         emitConst(1, rowA[k]);
         emitConst(2, rowB[k]);
         case (rowCls[k])
            clsR: emit(encR(rowF7[k], 2, 1, rowF3[k], 3));
            clsI: begin
               immOp = rowB[k][11:0];
               if (rowF3[k] == 3'b001 || rowF3[k] == 3'b101) immOp = {rowF7[k], rowB[k][4:0]};
               emit(encI(immOp, 1, rowF3[k], 3, opOpImm));
            end
            clsLui: emit(encU(rowB[k][19:0], 3));
            clsLw: begin
               mem[rowA[k][12:2]] = rowB[k];
               emit(encI(12'h0, 1, f3Word, 4, opLoad));
               emit(encI(12'h1, 4, 3'b000, 3, opOpImm));
            end
            default: emit(encR(7'h0, 2, 1, 3'b000, 0));
         endcase
         emit(encS(12'(4 * k), (rowCls[k] == clsX0) ? 5'd0 : 5'd3, 5));
      end
      haltIdx = pcIdx;
      emit({25'b0, opHalt});
      emit(encS(12'h7f0, 3, 5));
      // custom-0 opcode is not decoded
      emit(32'h0000_000b);
      emit(encS(12'h7f4, 3, 5));
   endtask

   task automatic timeoutFail(string what);
      $display("Timeout while waiting for %s", what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic runUntilHalt();
      int n;
      @(negedge clk);
      loadEn = 1'b1;
      @(negedge clk);
      loadEn = 1'b0;
      n = 0;
      while (!halt) begin
         @(negedge clk);
         n++;
         if (n > maxCycles) timeoutFail("the core to halt");
      end
      repeat (8) begin
         @(negedge clk);
         assert (!busRdy) else begin
            errCnt++;
            $display("Bus request seen after the core halted");
         end
      end
   endtask

   task automatic checkWord(string n, word_t addr, word_t exp);
      word_t got;
      got = mem[addr[12:2]];
      assert (got === exp) else begin
         errCnt++;
         $display("Fail %s: expected %h, actual %h", n, exp, got);
      end
   endtask

   initial begin
      int n;
      loadEn   = 1'b0;
      busVld   = 1'b0;
      busRData = '0;
      for (int i = 0; i < memWords; i++) mem[i] = ~word_t'(i * 4);
      addRow("add",   clsR,   3'b000, 7'h00, 32'h1234_5678, 32'h0fed_cba9, 32'h2222_2221);
      addRow("sub",   clsR,   3'b000, 7'h20, 32'd5,         32'd7,         32'hffff_fffe);
      addRow("sll",   clsR,   3'b001, 7'h00, 32'h8000_0001, 32'h0000_0024, 32'h0000_0010);
      addRow("slt",   clsR,   3'b010, 7'h00, 32'hffff_ffff, 32'd1,         32'd1);
      addRow("sltu",  clsR,   3'b011, 7'h00, 32'hffff_ffff, 32'd1,         32'd0);
      addRow("xor",   clsR,   3'b100, 7'h00, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
      addRow("srl",   clsR,   3'b101, 7'h00, 32'h8000_0000, 32'd31,        32'd1);
      addRow("sra",   clsR,   3'b101, 7'h20, 32'h8000_0000, 32'd4,         32'hf800_0000);
      addRow("or",    clsR,   3'b110, 7'h00, 32'h0000_00f0, 32'h0000_0f00, 32'h0000_0ff0);
      addRow("and",   clsR,   3'b111, 7'h00, 32'h1234_5678, 32'h0f0f_0f0f, 32'h0204_0608);
      addRow("addi",  clsI,   3'b000, 7'h00, 32'd100,       32'h0000_0ff6, 32'h0000_005a);
      addRow("slti",  clsI,   3'b010, 7'h00, 32'hffff_fffe, 32'h0000_0fff, 32'd1);
      addRow("sltiu", clsI,   3'b011, 7'h00, 32'd5,         32'h0000_0fff, 32'd1);
      addRow("xori",  clsI,   3'b100, 7'h00, 32'h0000_00ff, 32'h0000_0fff, 32'hffff_ff00);
      addRow("ori",   clsI,   3'b110, 7'h00, 32'h1200_0000, 32'h0000_0034, 32'h1200_0034);
      addRow("andi",  clsI,   3'b111, 7'h00, 32'hffff_ffff, 32'h0000_07f0, 32'h0000_07f0);
      addRow("slli",  clsI,   3'b001, 7'h00, 32'd3,         32'd30,        32'hc000_0000);
      addRow("srli",  clsI,   3'b101, 7'h00, 32'hf000_0000, 32'd28,        32'h0000_000f);
      addRow("srai",  clsI,   3'b101, 7'h20, 32'h9000_0000, 32'd8,         32'hff90_0000);
      addRow("lui",   clsLui, 3'b000, 7'h00, 32'd0,         32'h000a_bcde, 32'habcd_e000);
      addRow("lw",    clsLw,  3'b010, 7'h00, dataAddr,      32'h7fff_ffff, 32'h8000_0000);
      addRow("x0",    clsX0,  3'b000, 7'h00, 32'h1111_1111, 32'h2222_2222, 32'd0);
      buildProgram();

      n = 0;
      while (!rstn) begin
         @(negedge clk);
         n++;
         if (n > 4 * resetCycles) timeoutFail("reset release");
      end
      @(negedge clk);
      assert (halt && !busRdy && !busWEn) else begin
         errCnt++;
         $display("Core not idle and halted after reset");
      end

      // First run stops on the halt opcode
      runUntilHalt();
      for (int k = 0; k < rowName.size(); k++) begin
         checkWord(rowName[k], resBase + 4 * k, rowExp[k]);
      end
      checkWord("guardAfterHalt", guardAddr, ~guardAddr);

      // Second run steps over the halt and stops on the undefined opcode
      mem[haltIdx] = encI(12'h0, 0, 3'b000, 0, opOpImm);
      runUntilHalt();
      checkWord("guardAfterInvalid", invGuardAddr, ~invGuardAddr);

      $display("Errors: %0d", errCnt);
      if (errCnt == 0) begin
         $display("*** TEST PASSED ***");
      end
      else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- verif/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
   parameter int periodNs    = 100,
   parameter int resetCycles = 10
) (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

   // Reset released on a falling edge
   initial begin
      rstn = 1'b0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import lanzonesPkg::*; (
   input  word_t  rs1Data,
   input  word_t  rs2Data,
   input  word_t  imm,
   input  logic   useImm,
   input  aluOp_t aluOp,
   output word_t  aluResult
);

   word_t      opB;
   logic [4:0] shamt;

   assign opB   = useImm ? imm : rs2Data;
   assign shamt = opB[4:0];

   always_comb begin
      case (aluOp)
         aluAdd:   aluResult = rs1Data + opB;
         aluSub:   aluResult = rs1Data - opB;
         aluSll:   aluResult = rs1Data << shamt;
         aluSlt:   aluResult = ($signed(rs1Data) < $signed(opB)) ? 32'd1 : 32'd0;
         aluSltu:  aluResult = (rs1Data < opB) ? 32'd1 : 32'd0;
         aluXor:   aluResult = rs1Data ^ opB;
         aluSrl:   aluResult = rs1Data >> shamt;
         // Sign bit fills from the left
         aluSra:   aluResult = $signed(rs1Data) >>> shamt;
         aluOr:    aluResult = rs1Data | opB;
         aluAnd:   aluResult = rs1Data & opB;
         aluPassB: aluResult = opB;
         default:  aluResult = '0;
      endcase
   end

endmodule

//--- verilog/busSequencer.sv
`timescale 1ns/1ps

module busSequencer import lanzonesPkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    loadEn,
   output logic    halt,
   output logic    busRdy,
   output word_t   busAddr,
   output logic    busWEn,
   output word_t   busWData,
   input  logic    busVld,
   input  word_t   busRData,
   output word_t   instWord,
   input  logic    writesReg,
   input  logic    isLoad,
   input  logic    isStore,
   input  logic    stop,
   input  regIdx_t rd,
   input  word_t   rs2Data,
   input  word_t   aluResult,
   output logic    rfWEn,
   output regIdx_t rfWAddr,
   output word_t   rfWData
);

   typedef enum logic [1:0] {
      stFetch,
      stExec,
      stMem
   } seqState_t;

   seqState_t state;
   word_t     pc;
   word_t     nextPc;
   logic      xfer;

   assign nextPc = pc + word_t'(pcStep);
   assign xfer   = busRdy && busVld;

   // Control state
   always_ff @(posedge clk) begin
      if (!rstn) begin
         halt     <= 1'b1;
         busRdy   <= 1'b0;
         busWEn   <= 1'b0;
         pc       <= '0;
         instWord <= '0;
         state    <= stFetch;
      end
      else if (halt) begin
         if (loadEn) begin
            halt <= 1'b0;
         end
      end
      else begin
         case (state)
            stFetch: begin
               if (xfer) begin
                  instWord <= busRData;
                  busRdy   <= 1'b0;
                  state    <= stExec;
               end
               else if (!busRdy) begin
                  busRdy <= 1'b1;
               end
            end
            stExec: begin
               if (stop) begin
                  halt  <= 1'b1;
                  state <= stFetch;
               end
               else if (isLoad || isStore) begin
                  busRdy <= 1'b1;
                  busWEn <= isStore;
                  state  <= stMem;
               end
               else begin
                  pc     <= nextPc;
                  busRdy <= 1'b1;
                  state  <= stFetch;
               end
            end
            default: begin
               if (xfer) begin
                  busRdy <= 1'b0;
                  busWEn <= 1'b0;
                  pc     <= nextPc;
                  state  <= stFetch;
               end
            end
         endcase
      end
   end

   // Address and write data, loaded only when a request starts
   always_ff @(posedge clk) begin
      if (!halt) begin
         if ((state == stFetch) && !busRdy) begin
            busAddr <= pc;
         end
         else if ((state == stExec) && !stop) begin
            busAddr  <= (isLoad || isStore) ? aluResult : nextPc;
            busWData <= rs2Data;
         end
      end
   end

   // ALU results retire in execute, load data on the access transfer
   assign rfWEn = (state == stExec && !halt && !stop && writesReg && !isLoad) ||
                  (state == stMem && !halt && isLoad && xfer);
   assign rfWAddr = rd;
   assign rfWData = (state == stMem) ? busRData : aluResult;

endmodule

//--- verilog/instDecoder.sv
`timescale 1ns/1ps

module instDecoder import lanzonesPkg::*; (
   input  word_t   instWord,
   output regIdx_t rs1,
   output regIdx_t rs2,
   output regIdx_t rd,
   output word_t   imm,
   output aluOp_t  aluOp,
   output logic    useImm,
   output logic    writesReg,
   output logic    isLoad,
   output logic    isStore,
   output logic    stop
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      immI;
   word_t      immS;
   word_t      immShamt;
   word_t      immU;

   assign opcode = instWord[6:0];
   assign funct3 = instWord[14:12];
   assign funct7 = instWord[31:25];

   assign rs1 = instWord[19:15];
   assign rs2 = instWord[24:20];
   assign rd  = instWord[11:7];

   assign immI     = {{20{instWord[31]}}, instWord[31:20]};
   assign immS     = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
   assign immShamt = {27'b0, instWord[24:20]};
   assign immU     = {instWord[31:12], 12'b0};

   always_comb begin
      imm       = immI;
      aluOp     = aluAdd;
      useImm    = 1'b0;
      writesReg = 1'b0;
      isLoad    = 1'b0;
      isStore   = 1'b0;
      stop      = 1'b0;

      case (opcode)
         opOpImm: begin
            useImm    = 1'b1;
            writesReg = 1'b1;
            case (funct3)
               3'b000: aluOp = aluAdd;
               3'b010: aluOp = aluSlt;
               3'b011: aluOp = aluSltu;
               3'b100: aluOp = aluXor;
               3'b110: aluOp = aluOr;
               3'b111: aluOp = aluAnd;
               3'b001: begin
                  imm   = immShamt;
                  aluOp = aluSll;
                  stop  = (funct7 != 7'b0);
               end
               default: begin
                  // Right shifts, funct7 picks logical or arithmetic
                  imm   = immShamt;
                  aluOp = (funct7 == f7Alt) ? aluSra : aluSrl;
                  stop  = (funct7 != 7'b0) && (funct7 != f7Alt);
               end
            endcase
         end
         opOp: begin
            writesReg = 1'b1;
            if (funct7 == 7'b0) begin
               case (funct3)
                  3'b000:  aluOp = aluAdd;
                  3'b001:  aluOp = aluSll;
                  3'b010:  aluOp = aluSlt;
                  3'b011:  aluOp = aluSltu;
                  3'b100:  aluOp = aluXor;
                  3'b101:  aluOp = aluSrl;
                  3'b110:  aluOp = aluOr;
                  default: aluOp = aluAnd;
               endcase
            end
            else if ((funct7 == f7Alt) && (funct3 == 3'b000)) begin
               aluOp = aluSub;
            end
            else if ((funct7 == f7Alt) && (funct3 == 3'b101)) begin
               aluOp = aluSra;
            end
            else begin
               stop = 1'b1;
            end
         end
         opLui: begin
            imm       = immU;
            aluOp     = aluPassB;
            useImm    = 1'b1;
            writesReg = 1'b1;
         end
         opLoad: begin
            useImm    = 1'b1;
            writesReg = 1'b1;
            isLoad    = 1'b1;
            stop      = (funct3 != f3Word);
         end
         opStore: begin
            imm     = immS;
            useImm  = 1'b1;
            isStore = 1'b1;
            stop    = (funct3 != f3Word);
         end
         // opHalt lands here too
         default: stop = 1'b1;
      endcase
   end

endmodule

//--- verilog/lanzonesCore.sv
`timescale 1ns/1ps

module lanzonesCore import lanzonesPkg::*; (
   input  logic  clk,
   input  logic  rstn,
   input  logic  loadEn,
   output logic  halt,
   output logic  busRdy,
   output word_t busAddr,
   output logic  busWEn,
   output word_t busWData,
   input  logic  busVld,
   input  word_t busRData
);

   word_t   instWord;
   regIdx_t rs1;
   regIdx_t rs2;
   regIdx_t rd;
   word_t   imm;
   aluOp_t  aluOp;
   logic    useImm;
   logic    writesReg;
   logic    isLoad;
   logic    isStore;
   logic    stop;
   word_t   rs1Data;
   word_t   rs2Data;
   word_t   aluResult;
   logic    rfWEn;
   regIdx_t rfWAddr;
   word_t   rfWData;

   regFile i_regFile (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (rs1),
      .rs2     (rs2),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .rfWEn   (rfWEn),
      .rfWAddr (rfWAddr),
      .rfWData (rfWData)
   );

   instDecoder i_instDecoder (
      .instWord  (instWord),
      .rs1       (rs1),
      .rs2       (rs2),
      .rd        (rd),
      .imm       (imm),
      .aluOp     (aluOp),
      .useImm    (useImm),
      .writesReg (writesReg),
      .isLoad    (isLoad),
      .isStore   (isStore),
      .stop      (stop)
   );

   aluUnit i_aluUnit (
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .imm       (imm),
      .useImm    (useImm),
      .aluOp     (aluOp),
      .aluResult (aluResult)
   );

   busSequencer i_busSequencer (
      .clk       (clk),
      .rstn      (rstn),
      .loadEn    (loadEn),
      .halt      (halt),
      .busRdy    (busRdy),
      .busAddr   (busAddr),
      .busWEn    (busWEn),
      .busWData  (busWData),
      .busVld    (busVld),
      .busRData  (busRData),
      .instWord  (instWord),
      .writesReg (writesReg),
      .isLoad    (isLoad),
      .isStore   (isStore),
      .stop      (stop),
      .rd        (rd),
      .rs2Data   (rs2Data),
      .aluResult (aluResult),
      .rfWEn     (rfWEn),
      .rfWAddr   (rfWAddr),
      .rfWData   (rfWData)
   );

endmodule

//--- verilog/lanzonesPkg.sv
package lanzonesPkg;

   // Data path and register file sizes
   localparam int xlen     = 32;
   localparam int regAddrW = 5;
   localparam int nRegs    = 32;

   typedef logic [xlen-1:0]     word_t;
   typedef logic [regAddrW-1:0] regIdx_t;

   // Major opcodes, instruction bits [6:0]
   localparam logic [6:0] opOpImm = 7'b0010011;
   localparam logic [6:0] opOp    = 7'b0110011;
   localparam logic [6:0] opLui   = 7'b0110111;
   localparam logic [6:0] opLoad  = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   // All seven low bits set stops the core
   localparam logic [6:0] opHalt  = 7'b1111111;

   // Word-sized load and store
   localparam logic [2:0] f3Word = 3'b010;

   // Selects SUB over ADD and SRA over SRL
   localparam logic [6:0] f7Alt = 7'b0100000;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,
      aluSltu,
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd,
      aluPassB
   } aluOp_t;

   // No jumps or branches, so the PC only steps by one word
   localparam int pcStep = 4;

endpackage

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile import lanzonesPkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  regIdx_t rs1,
   input  regIdx_t rs2,
   output word_t   rs1Data,
   output word_t   rs2Data,
   input  logic    rfWEn,
   input  regIdx_t rfWAddr,
   input  word_t   rfWData
);

   word_t regs [nRegs];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < nRegs; i++) begin
            regs[i] <= '0;
         end
      end
      else if (rfWEn && (rfWAddr != '0)) begin
         // x0 is never written and stays zero from reset
         regs[rfWAddr] <= rfWData;
      end
   end

   assign rs1Data = regs[rs1];
   assign rs2Data = regs[rs2];

endmodule
